//--- compile.f
+incdir+rtl
rtl/pq_pkg.sv
rtl/pq_tree_if.sv
rtl/node_comparator.sv
rtl/heap_tree.sv
rtl/heap_sequencer.sv
rtl/priority_queue_top.sv
testbench/tb_priority_queue.sv

//--- rtl/heap_sequencer.sv
`timescale 1ns/1ps

`include "pq_defs.svh"

module heap_sequencer
  import pq_pkg::*;
#(
  parameter int DATA_WIDTH = `PQ_DATA_WIDTH
) (
  input  logic                  CLK,
  input  logic                  RSTn,
  input  logic                  i_replace,
  input  logic [DATA_WIDTH-1:0] i_data,
  output logic                  o_ready,
  pq_tree_if.seq_mp             seq_mp
);

  pq_state_t             state_q;
  pq_state_t             state_d;
  logic                  even_swapped_q;
  logic [DATA_WIDTH-1:0] replace_data_q;
  logic                  accept;

  assign o_ready = (state_q == ST_IDLE);
  assign accept  = o_ready && i_replace;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_replace) begin
          state_d = ST_REPLACE;
        end
      end
      ST_REPLACE: begin
        state_d = ST_EVEN;
      end
      ST_EVEN: begin
        state_d = ST_ODD;
      end
      ST_ODD: begin
        // Settled once both phases in a row left the tree untouched
        if (!seq_mp.swapped && !even_swapped_q) begin
          state_d = ST_IDLE;
        end else begin
          state_d = ST_EVEN;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge RSTn) begin
    if (!RSTn) begin
      state_q        <= ST_IDLE;
      even_swapped_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_EVEN) begin
        even_swapped_q <= seq_mp.swapped;
      end
    end
  end

  // Value held until the root-load cycle
  always_ff @(posedge CLK) begin
    if (accept) begin
      replace_data_q <= i_data;
    end
  end

  assign seq_mp.load_root = (state_q == ST_REPLACE);
  assign seq_mp.load_data = replace_data_q;

  always_comb begin
    case (state_q)
      ST_EVEN: seq_mp.phase = PH_EVEN;
      ST_ODD:  seq_mp.phase = PH_ODD;
      default: seq_mp.phase = PH_NONE;
    endcase
  end

endmodule

//--- rtl/heap_tree.sv
`timescale 1ns/1ps

`include "pq_defs.svh"

module heap_tree
  import pq_pkg::*;
#(
  parameter int QUEUE_SIZE = `PQ_QUEUE_SIZE,
  parameter int DATA_WIDTH = `PQ_DATA_WIDTH
) (
  input  logic                  CLK,
  input  logic                  RSTn,
  pq_tree_if.tree_mp            tree_mp,
  output logic [DATA_WIDTH-1:0] o_root
);

  // Full binary tree large enough for QUEUE_SIZE data nodes
  localparam int TREE_DEPTH = $clog2(QUEUE_SIZE);
  localparam int NODE_COUNT = (1 << (TREE_DEPTH + 1)) - 1;
  localparam int COMP_COUNT = NODE_COUNT / 2;

  logic [DATA_WIDTH-1:0] node_q    [NODE_COUNT];

  // Comparator results, indexed by the parent node of each triplet
  logic [DATA_WIDTH-1:0] new_parent [COMP_COUNT];
  logic [DATA_WIDTH-1:0] new_left   [COMP_COUNT];
  logic [DATA_WIDTH-1:0] new_right  [COMP_COUNT];
  logic [COMP_COUNT-1:0] swap;

  // Swap flags split by parent level parity
  logic [COMP_COUNT-1:0] even_swap;
  logic [COMP_COUNT-1:0] odd_swap;

  for (genvar j = 0; j < COMP_COUNT; j++) begin : g_triplet
    localparam int LEVEL = $clog2(j + 2) - 1;

    node_comparator #(
      .DATA_WIDTH(DATA_WIDTH)
    ) i_node_comparator (
      .i_parent      (node_q[j]),
      .i_left_child  (node_q[2*j + 1]),
      .i_right_child (node_q[2*j + 2]),
      .o_parent      (new_parent[j]),
      .o_left_child  (new_left[j]),
      .o_right_child (new_right[j]),
      .o_swap        (swap[j])
    );

    assign even_swap[j] = (LEVEL % 2 == 0) ? swap[j] : 1'b0;
    assign odd_swap[j]  = (LEVEL % 2 == 1) ? swap[j] : 1'b0;
  end

  // Each node is written either by its own triplet or by the one above,
  // and those two triplets always sit on levels of opposite parity
  for (genvar n = 0; n < NODE_COUNT; n++) begin : g_node
    localparam int LEVEL = $clog2(n + 2) - 1;
    localparam logic [DATA_WIDTH-1:0] INIT_VALUE =
      (n < QUEUE_SIZE) ? DATA_WIDTH'((QUEUE_SIZE - n) * 10) : '0;
    localparam pq_phase_t OWN_PHASE = (LEVEL % 2 == 0) ? PH_EVEN : PH_ODD;
    localparam pq_phase_t UP_PHASE  = (LEVEL % 2 == 0) ? PH_ODD : PH_EVEN;

    logic [DATA_WIDTH-1:0] as_parent_value;
    logic [DATA_WIDTH-1:0] as_child_value;

    if (n < COMP_COUNT) begin : g_inner
      assign as_parent_value = new_parent[n];
    end else begin : g_leaf
      assign as_parent_value = node_q[n];
    end

    if (n == 0) begin : g_root
      assign as_child_value = node_q[n];
    end else if (n % 2 == 1) begin : g_left
      assign as_child_value = new_left[(n - 1) / 2];
    end else begin : g_right
      assign as_child_value = new_right[(n - 1) / 2];
    end

    always_ff @(posedge CLK or negedge RSTn) begin
      if (!RSTn) begin
        node_q[n] <= INIT_VALUE;
      end else if ((n == 0) && tree_mp.load_root) begin
        node_q[n] <= tree_mp.load_data;
      end else if (tree_mp.phase == OWN_PHASE) begin
        node_q[n] <= as_parent_value;
      end else if (tree_mp.phase == UP_PHASE) begin
        node_q[n] <= as_child_value;
      end
    end
  end

  // Only the triplets of the active phase count as a change
  always_comb begin
    case (tree_mp.phase)
      PH_EVEN: tree_mp.swapped = |even_swap;
      PH_ODD:  tree_mp.swapped = |odd_swap;
      default: tree_mp.swapped = 1'b0;
    endcase
  end

  assign o_root = node_q[0];

endmodule

//--- rtl/node_comparator.sv
`timescale 1ns/1ps

`include "pq_defs.svh"

module node_comparator #(
  parameter int DATA_WIDTH = `PQ_DATA_WIDTH
) (
  input  logic [DATA_WIDTH-1:0] i_parent,
  input  logic [DATA_WIDTH-1:0] i_left_child,
  input  logic [DATA_WIDTH-1:0] i_right_child,
  output logic [DATA_WIDTH-1:0] o_parent,
  output logic [DATA_WIDTH-1:0] o_left_child,
  output logic [DATA_WIDTH-1:0] o_right_child,
  output logic                  o_swap
);

  always_comb begin
    o_parent      = i_parent;
    o_left_child  = i_left_child;
    o_right_child = i_right_child;
    o_swap        = 1'b0;

    // Parent already largest, ties keep it in place
    if ((i_parent >= i_left_child) && (i_parent >= i_right_child)) begin
      o_swap = 1'b0;
    end else if (i_left_child >= i_right_child) begin
      // Left wins ties against right
      o_parent     = i_left_child;
      o_left_child = i_parent;
      o_swap       = 1'b1;
    end else begin
      o_parent      = i_right_child;
      o_right_child = i_parent;
      o_swap        = 1'b1;
    end
  end

endmodule

//--- rtl/pq_defs.svh
`ifndef PQ_DEFS_SVH
`define PQ_DEFS_SVH

// Number of data nodes held in the queue
`define PQ_QUEUE_SIZE 8

// Width of every node value in bits
`define PQ_DATA_WIDTH 32

`endif

//--- rtl/pq_pkg.sv
package pq_pkg;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'b00,
    ST_REPLACE = 2'b01,
    ST_EVEN    = 2'b10,
    ST_ODD     = 2'b11
  } pq_state_t;

  // Level parity that updates in the current cycle
  typedef enum logic [1:0] {
    PH_NONE = 2'b00,
    PH_EVEN = 2'b01,
    PH_ODD  = 2'b10
  } pq_phase_t;

endpackage

//--- rtl/pq_tree_if.sv
`timescale 1ns/1ps

`include "pq_defs.svh"

interface pq_tree_if
  import pq_pkg::*;
#(
  parameter int DATA_WIDTH = `PQ_DATA_WIDTH
) ();

  logic                  load_root;
  logic [DATA_WIDTH-1:0] load_data;
  pq_phase_t             phase;
  logic                  swapped;

  modport seq_mp (
    output load_root,
    output load_data,
    output phase,
    input  swapped
  );

  modport tree_mp (
    input  load_root,
    input  load_data,
    input  phase,
    output swapped
  );

endinterface

//--- rtl/priority_queue_top.sv
`timescale 1ns/1ps

`include "pq_defs.svh"

module priority_queue_top (
  input  logic                      CLK,
  input  logic                      RSTn,
  input  logic                      i_replace,
  input  logic [`PQ_DATA_WIDTH-1:0] i_data,
  output logic [`PQ_DATA_WIDTH-1:0] o_data,
  output logic                      o_ready
);

  // Control and swap status between sequencer and tree
  pq_tree_if #(
    .DATA_WIDTH(`PQ_DATA_WIDTH)
  ) tree_bus ();

  heap_sequencer #(
    .DATA_WIDTH(`PQ_DATA_WIDTH)
  ) i_heap_sequencer (
    .CLK       (CLK),
    .RSTn      (RSTn),
    .i_replace (i_replace),
    .i_data    (i_data),
    .o_ready   (o_ready),
    .seq_mp    (tree_bus.seq_mp)
  );

  // Root of the tree is the queue maximum
  heap_tree #(
    .QUEUE_SIZE(`PQ_QUEUE_SIZE),
    .DATA_WIDTH(`PQ_DATA_WIDTH)
  ) i_heap_tree (
    .CLK     (CLK),
    .RSTn    (RSTn),
    .tree_mp (tree_bus.tree_mp),
    .o_root  (o_data)
  );

endmodule

//--- testbench/tb_priority_queue.sv
`timescale 1ns/1ps

`include "pq_defs.svh"

module tb_priority_queue
  import pq_pkg::*;
;

  localparam int W            = `PQ_DATA_WIDTH;
  localparam int QUEUE_SIZE   = `PQ_QUEUE_SIZE;
  localparam int LEVELS       = $clog2(QUEUE_SIZE) + 1;
  localparam int NODE_COUNT   = (1 << LEVELS) - 1;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_LATENCY  = 2 * (LEVELS + 1) + 2;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_OPS      = NUM_RANDOM + 4;
  localparam int TIMEOUT_NS   = (NUM_OPS * 16 + RESET_CYCLES + 8) * CLK_PERIOD;

  logic         CLK;
  logic         RSTn;
  logic         i_replace;
  logic [W-1:0] i_data;
  logic [W-1:0] o_data;
  logic         o_ready;

  // Multiset of all node values, padding zeros included
  logic [W-1:0] ref_nodes [NODE_COUNT];

  logic [W-1:0] expect_q [$];
  string        name_q   [$];
  int           accepted_count = 0;
  int           compared_count = 0;

  int     check_count  = 0;
  int     data_errors  = 0;
  int     ready_errors = 0;
  int     state_errors = 0;
  int     timeouts     = 0;
  integer seed;

  priority_queue_top i_priority_queue_top (
    .CLK       (CLK),
    .RSTn      (RSTn),
    .i_replace (i_replace),
    .i_data    (i_data),
    .o_data    (o_data),
    .o_ready   (o_ready)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [W-1:0] model_max();
    logic [W-1:0] max_val;
    max_val = ref_nodes[0];
    for (int i = 1; i < NODE_COUNT; i++) begin
      if (ref_nodes[i] > max_val) begin
        max_val = ref_nodes[i];
      end
    end
    return max_val;
  endfunction

  // Drop the current maximum, add the new value, report the new maximum
  function automatic logic [W-1:0] replace_top(input logic [W-1:0] value);
    int max_idx;
    max_idx = 0;
    for (int i = 1; i < NODE_COUNT; i++) begin
      if (ref_nodes[i] > ref_nodes[max_idx]) begin
        max_idx = i;
      end
    end
    ref_nodes[max_idx] = value;
    return model_max();
  endfunction

  task automatic check_data(input string name, input logic [W-1:0] expected,
                            input logic [W-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      data_errors++;
      $display("** Error [%s]: expected data %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_ready(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      ready_errors++;
      $display("** Error [%s]: expected ready %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_state(input string name, input pq_state_t expected,
                             input pq_state_t actual);
    check_count++;
    if (actual !== expected) begin
      state_errors++;
      $display("** Error [%s]: expected state %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Optionally keeps the strobe high through the load cycle and both phases
  task automatic do_replace(input string name, input logic [W-1:0] value,
                            input bit with_drop, input logic [W-1:0] drop_value);
    @(negedge CLK);
    while (!o_ready) begin
      @(negedge CLK);
    end
    @(posedge CLK);
    i_replace <= 1'b1;
    i_data    <= value;
    // Request is taken at this edge
    @(posedge CLK);
    expect_q.push_back(replace_top(value));
    name_q.push_back(name);
    accepted_count++;
    if (with_drop) begin
      i_data <= drop_value;
      repeat (3) @(posedge CLK);
    end
    i_replace <= 1'b0;
  endtask

  // Compare process, one pass per accepted replace
  initial begin : compare_proc
    string        name;
    logic [W-1:0] expected;
    int           waited;
    forever begin
      wait (accepted_count > compared_count);
      name     = name_q.pop_front();
      expected = expect_q.pop_front();
      @(negedge CLK);
      check_ready({name, " busy"}, 1'b0, o_ready);
      check_state({name, " load"}, ST_REPLACE, i_priority_queue_top.i_heap_sequencer.state_q);
      waited = 0;
      while (!o_ready && waited < MAX_LATENCY) begin
        @(negedge CLK);
        waited++;
      end
      if (!o_ready) begin
        timeouts++;
        $display("%s: ready did not return after replace within %0d cycles",
                 name, MAX_LATENCY);
      end else begin
        check_data(name, expected, o_data);
        check_state({name, " settled"}, ST_IDLE,
                    i_priority_queue_top.i_heap_sequencer.state_q);
      end
      compared_count++;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Run stopped by timeout after %0d ns, %0d of %0d replaces checked",
             TIMEOUT_NS, compared_count, NUM_OPS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : stimulus
    logic [W-1:0] value;
    CLK       = 1'b0;
    RSTn      = 1'b0;
    i_replace = 1'b0;
    i_data    = '0;
    seed      = 32'h31015c5f;
    for (int i = 0; i < NODE_COUNT; i++) begin
      ref_nodes[i] = (i < QUEUE_SIZE) ? W'((QUEUE_SIZE - i) * 10) : '0;
    end

    repeat (RESET_CYCLES) @(posedge CLK);
    RSTn <= 1'b1;

    @(negedge CLK);
    check_ready("reset ready", 1'b1, o_ready);
    check_data("reset data", model_max(), o_data);
    check_state("reset state", ST_IDLE, i_priority_queue_top.i_heap_sequencer.state_q);

    do_replace("replace larger than all", 32'hFFFF_0000, 1'b0, '0);
    // Zero at the root sinks through every level
    do_replace("replace with zero", '0, 1'b0, '0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      value = $random(seed);
      do_replace($sformatf("random replace %0d", n), value, 1'b0, '0);
    end

    do_replace("request while busy", '0, 1'b1, 32'hFFFF_FFFF);
    do_replace("after dropped request", 32'd5, 1'b0, '0);

    wait (compared_count == accepted_count);
    repeat (2) @(posedge CLK);
    $display("checks %0d, data errors %0d, ready errors %0d, state errors %0d, timeouts %0d",
             check_count, data_errors, ready_errors, state_errors, timeouts);
    if ((data_errors + ready_errors + state_errors + timeouts) == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
